/* verilog/dmac_ahb_pkg.sv */
/*
 * AHB bus types for the DMA channel register block.
 * Transfer type encoding, address phase bundle and data width.
 */
`default_nettype none

package dmac_ahb_pkg;

  localparam int DATA_W = 32;

  // encoding follows the AHB htrans field
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_e;

  // address phase signals as seen by a slave
  typedef struct packed {
    logic        hsel;
    htrans_e     htrans;
    logic [31:0] haddr;
    logic        hwrite;
  } ahb_req_t;

endpackage

`default_nettype wire

/* verilog/dmac_reg_pkg.sv */
/*
 * Register map of one DMA channel.
 * Offsets, field positions, access and configuration types.
 */
`default_nettype none

package dmac_reg_pkg;

  localparam int REG_ADDR_W = 10;

  localparam logic [REG_ADDR_W-1:0] CHN_BASE = 10'h1b0;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // register offsets from the channel base
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam logic [REG_ADDR_W-1:0] OFS_SAR        = 10'h000;
  localparam logic [REG_ADDR_W-1:0] OFS_DAR        = 10'h004;
  localparam logic [REG_ADDR_W-1:0] OFS_CTRL_A     = 10'h008;
  localparam logic [REG_ADDR_W-1:0] OFS_CTRL_B     = 10'h00c;
  localparam logic [REG_ADDR_W-1:0] OFS_INT_MASK   = 10'h010;
  localparam logic [REG_ADDR_W-1:0] OFS_INT_STATUS = 10'h014;
  localparam logic [REG_ADDR_W-1:0] OFS_INT_CLEAR  = 10'h018;
  localparam logic [REG_ADDR_W-1:0] OFS_SOFT_REQ   = 10'h01c;
  localparam logic [REG_ADDR_W-1:0] OFS_CHN_EN     = 10'h020;
  localparam logic [REG_ADDR_W-1:0] OFS_GRPLEN_EXT = 10'h024;

  // ctrl_a fields, single bits or the low bit of a field
  localparam int CA_DGRPADDRC  = 31;
  localparam int CA_SGRPADDRC  = 29;
  localparam int CA_GRPMC      = 28;
  localparam int CA_CHINTMDC   = 24;
  localparam int CA_BLOCK_TL   = 12;
  localparam int CA_GROUP_LEN  = 8;
  localparam int CA_SINC       = 6;
  localparam int CA_DINC       = 4;
  localparam int CA_SRC_TR_W   = 2;
  localparam int CA_DST_TR_W   = 0;

  // upper two bits of group_len live in their own register
  localparam int GE_GROUP_LEN  = 0;

  // ctrl_b fields
  localparam int CB_PROTCTL    = 15;
  localparam int CB_ENDLAN     = 14;
  localparam int CB_SRCDTLGC   = 13;
  localparam int CB_TRGTMDC    = 1;
  localparam int CB_INT_EN     = 0;

  localparam int CHN_EN_BIT    = 0;
  localparam int SOFT_REQ_BIT  = 0;
  localparam int EVT_W         = 5;

  typedef enum logic [3:0] {
    REG_NONE,
    REG_SAR,
    REG_DAR,
    REG_CTRL_A,
    REG_CTRL_B,
    REG_INT_MASK,
    REG_INT_STATUS,
    REG_INT_CLEAR,
    REG_SOFT_REQ,
    REG_CHN_EN,
    REG_GRPLEN_EXT
  } reg_sel_e;

  // register access for the data phase
  typedef struct packed {
    reg_sel_e sel;
    logic     wr;
    logic     rd;
  } reg_acc_t;

  typedef struct packed {
    logic [31:0] sar;
    logic [31:0] dar;
    logic        dgrpaddrc;
    logic        sgrpaddrc;
    logic        grpmc;
    logic [2:0]  chintmdc;
    logic [11:0] block_tl;
    logic [5:0]  group_len;
    logic [1:0]  sinc;
    logic [1:0]  dinc;
    logic [1:0]  src_tr_width;
    logic [1:0]  dst_tr_width;
    logic [3:0]  protctl;
    logic        endlan;
    logic        srcdtlgc;
    logic [1:0]  trgtmdc;
  } xfer_cfg_t;

  // same layout for events, mask, status and clear
  typedef struct packed {
    logic pend;
    logic trgetcmp;
    logic htfr;
    logic tfr;
    logic err;
  } chn_evt_t;

endpackage

`default_nettype wire

/* verilog/dmac_ahb_decode.sv */
/*
 * AHB address phase decoder. Registers a valid transfer as a register
 * access for the data phase and blocks configuration writes while enabled.
 */
`default_nettype none

module dmac_ahb_decode (
  input  wire                    hclk,
  input  wire                    hrst_n,
  input  wire dmac_ahb_pkg::ahb_req_t ahb_req,
  input  wire                    chn_en,
  output dmac_reg_pkg::reg_acc_t acc
);

  logic                                active;
  logic [dmac_reg_pkg::REG_ADDR_W-1:0] ofs;
  dmac_reg_pkg::reg_sel_e              sel_map;
  logic                                cfg_hit;
  dmac_reg_pkg::reg_acc_t              acc_nxt;

  assign active = ahb_req.hsel &&
                  (ahb_req.htrans == dmac_ahb_pkg::NONSEQ ||
                   ahb_req.htrans == dmac_ahb_pkg::SEQ);

  // addresses below the base wrap far past the last offset
  assign ofs = ahb_req.haddr[dmac_reg_pkg::REG_ADDR_W-1:0] - dmac_reg_pkg::CHN_BASE;

  always_comb begin
    case (ofs)
      dmac_reg_pkg::OFS_SAR:        sel_map = dmac_reg_pkg::REG_SAR;
      dmac_reg_pkg::OFS_DAR:        sel_map = dmac_reg_pkg::REG_DAR;
      dmac_reg_pkg::OFS_CTRL_A:     sel_map = dmac_reg_pkg::REG_CTRL_A;
      dmac_reg_pkg::OFS_CTRL_B:     sel_map = dmac_reg_pkg::REG_CTRL_B;
      dmac_reg_pkg::OFS_INT_MASK:   sel_map = dmac_reg_pkg::REG_INT_MASK;
      dmac_reg_pkg::OFS_INT_STATUS: sel_map = dmac_reg_pkg::REG_INT_STATUS;
      dmac_reg_pkg::OFS_INT_CLEAR:  sel_map = dmac_reg_pkg::REG_INT_CLEAR;
      dmac_reg_pkg::OFS_SOFT_REQ:   sel_map = dmac_reg_pkg::REG_SOFT_REQ;
      dmac_reg_pkg::OFS_CHN_EN:     sel_map = dmac_reg_pkg::REG_CHN_EN;
      dmac_reg_pkg::OFS_GRPLEN_EXT: sel_map = dmac_reg_pkg::REG_GRPLEN_EXT;
      default:                      sel_map = dmac_reg_pkg::REG_NONE;
    endcase
  end

  assign cfg_hit = sel_map inside {dmac_reg_pkg::REG_SAR, dmac_reg_pkg::REG_DAR,
                                   dmac_reg_pkg::REG_CTRL_A, dmac_reg_pkg::REG_CTRL_B,
                                   dmac_reg_pkg::REG_GRPLEN_EXT};

  always_comb begin
    acc_nxt.sel = active ? sel_map : dmac_reg_pkg::REG_NONE;
    // the transfer configuration is frozen while the channel runs
    if (ahb_req.hwrite && chn_en && cfg_hit) begin
      acc_nxt.sel = dmac_reg_pkg::REG_NONE;
    end
    acc_nxt.wr = (acc_nxt.sel != dmac_reg_pkg::REG_NONE) && ahb_req.hwrite;
    acc_nxt.rd = (acc_nxt.sel != dmac_reg_pkg::REG_NONE) && !ahb_req.hwrite;
  end

  always_ff @(posedge hclk or negedge hrst_n) begin
    if (!hrst_n) begin
      acc.sel <= dmac_reg_pkg::REG_NONE;
      acc.wr  <= 1'b0;
      acc.rd  <= 1'b0;
    end else begin
      acc <= acc_nxt;
    end
  end

  // an enabled channel in the address phase means no config write in the data phase
  a_cfg_locked: assert property (@(posedge hclk) disable iff (!hrst_n)
    chn_en |=> !(acc.wr && acc.sel inside {dmac_reg_pkg::REG_SAR, dmac_reg_pkg::REG_DAR,
                                           dmac_reg_pkg::REG_CTRL_A, dmac_reg_pkg::REG_CTRL_B,
                                           dmac_reg_pkg::REG_GRPLEN_EXT}))
    else $error("config register written while channel enabled");

endmodule

`default_nettype wire

/* verilog/dmac_cfg_regs.sv */
/*
 * Transfer configuration registers of one DMA channel and their read word.
 */
`default_nettype none

module dmac_cfg_regs (
  input  wire                               hclk,
  input  wire                               hrst_n,
  input  wire dmac_reg_pkg::reg_acc_t       acc,
  input  wire [dmac_ahb_pkg::DATA_W-1:0]    hwdata,
  output dmac_reg_pkg::xfer_cfg_t           cfg,
  output logic                              int_en,
  output logic [dmac_ahb_pkg::DATA_W-1:0]   cfg_rdata
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // register write
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge hclk or negedge hrst_n) begin
    if (!hrst_n) begin
      cfg    <= '0;
      int_en <= 1'b0;
    end else if (acc.wr) begin
      case (acc.sel)
        dmac_reg_pkg::REG_SAR: cfg.sar <= hwdata;
        dmac_reg_pkg::REG_DAR: cfg.dar <= hwdata;
        dmac_reg_pkg::REG_CTRL_A: begin
          cfg.dgrpaddrc      <= hwdata[dmac_reg_pkg::CA_DGRPADDRC];
          cfg.sgrpaddrc      <= hwdata[dmac_reg_pkg::CA_SGRPADDRC];
          cfg.grpmc          <= hwdata[dmac_reg_pkg::CA_GRPMC];
          cfg.chintmdc       <= hwdata[dmac_reg_pkg::CA_CHINTMDC +: 3];
          cfg.block_tl       <= hwdata[dmac_reg_pkg::CA_BLOCK_TL +: 12];
          cfg.group_len[3:0] <= hwdata[dmac_reg_pkg::CA_GROUP_LEN +: 4];
          cfg.sinc           <= hwdata[dmac_reg_pkg::CA_SINC +: 2];
          cfg.dinc           <= hwdata[dmac_reg_pkg::CA_DINC +: 2];
          cfg.src_tr_width   <= hwdata[dmac_reg_pkg::CA_SRC_TR_W +: 2];
          cfg.dst_tr_width   <= hwdata[dmac_reg_pkg::CA_DST_TR_W +: 2];
        end
        dmac_reg_pkg::REG_GRPLEN_EXT: begin
          cfg.group_len[5:4] <= hwdata[dmac_reg_pkg::GE_GROUP_LEN +: 2];
        end
        dmac_reg_pkg::REG_CTRL_B: begin
          cfg.protctl  <= hwdata[dmac_reg_pkg::CB_PROTCTL +: 4];
          cfg.endlan   <= hwdata[dmac_reg_pkg::CB_ENDLAN];
          cfg.srcdtlgc <= hwdata[dmac_reg_pkg::CB_SRCDTLGC];
          cfg.trgtmdc  <= hwdata[dmac_reg_pkg::CB_TRGTMDC +: 2];
          int_en       <= hwdata[dmac_reg_pkg::CB_INT_EN];
        end
        default: ;
      endcase
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // read word, reserved bits stay zero
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    cfg_rdata = '0;
    if (acc.rd) begin
      case (acc.sel)
        dmac_reg_pkg::REG_SAR: cfg_rdata = cfg.sar;
        dmac_reg_pkg::REG_DAR: cfg_rdata = cfg.dar;
        dmac_reg_pkg::REG_CTRL_A: begin
          cfg_rdata[dmac_reg_pkg::CA_DGRPADDRC]      = cfg.dgrpaddrc;
          cfg_rdata[dmac_reg_pkg::CA_SGRPADDRC]      = cfg.sgrpaddrc;
          cfg_rdata[dmac_reg_pkg::CA_GRPMC]          = cfg.grpmc;
          cfg_rdata[dmac_reg_pkg::CA_CHINTMDC +: 3]  = cfg.chintmdc;
          cfg_rdata[dmac_reg_pkg::CA_BLOCK_TL +: 12] = cfg.block_tl;
          cfg_rdata[dmac_reg_pkg::CA_GROUP_LEN +: 4] = cfg.group_len[3:0];
          cfg_rdata[dmac_reg_pkg::CA_SINC +: 2]      = cfg.sinc;
          cfg_rdata[dmac_reg_pkg::CA_DINC +: 2]      = cfg.dinc;
          cfg_rdata[dmac_reg_pkg::CA_SRC_TR_W +: 2]  = cfg.src_tr_width;
          cfg_rdata[dmac_reg_pkg::CA_DST_TR_W +: 2]  = cfg.dst_tr_width;
        end
        dmac_reg_pkg::REG_GRPLEN_EXT: begin
          cfg_rdata[dmac_reg_pkg::GE_GROUP_LEN +: 2] = cfg.group_len[5:4];
        end
        dmac_reg_pkg::REG_CTRL_B: begin
          cfg_rdata[dmac_reg_pkg::CB_PROTCTL +: 4] = cfg.protctl;
          cfg_rdata[dmac_reg_pkg::CB_ENDLAN]       = cfg.endlan;
          cfg_rdata[dmac_reg_pkg::CB_SRCDTLGC]     = cfg.srcdtlgc;
          cfg_rdata[dmac_reg_pkg::CB_TRGTMDC +: 2] = cfg.trgtmdc;
          cfg_rdata[dmac_reg_pkg::CB_INT_EN]       = int_en;
        end
        default: ;
      endcase
    end
  end

  // the decoder derives both strobes from one hwrite sample
  a_wr_rd_excl: assert property (@(posedge hclk) disable iff (!hrst_n)
    !(acc.wr && acc.rd))
    else $error("register access is both read and write");

endmodule

`default_nettype wire

/* verilog/dmac_chn_ctl.sv */
/*
 * Channel control registers: enable, software request and interrupts.
 * Also selects the read data returned on the bus.
 */
`default_nettype none

module dmac_chn_ctl (
  input  wire                               hclk,
  input  wire                               hrst_n,
  input  wire dmac_reg_pkg::reg_acc_t       acc,
  input  wire [dmac_ahb_pkg::DATA_W-1:0]    hwdata,
  input  wire dmac_reg_pkg::chn_evt_t       evt,
  input  wire                               chnen_clr,
  input  wire                               int_en,
  input  wire [dmac_ahb_pkg::DATA_W-1:0]    cfg_rdata,
  output logic                              chn_en,
  output logic                              irq,
  output logic                              pend,
  output logic                              sfwtrg,
  output logic [dmac_ahb_pkg::DATA_W-1:0]   hrdata
);

  dmac_reg_pkg::chn_evt_t int_mask;
  dmac_reg_pkg::chn_evt_t int_status;
  dmac_reg_pkg::chn_evt_t int_clear;
  logic                   soft_req;
  logic                   wr_mask;
  logic                   wr_clear;
  logic                   wr_soft;
  logic                   wr_en;

  assign wr_mask  = acc.wr && acc.sel == dmac_reg_pkg::REG_INT_MASK;
  assign wr_clear = acc.wr && acc.sel == dmac_reg_pkg::REG_INT_CLEAR;
  assign wr_soft  = acc.wr && acc.sel == dmac_reg_pkg::REG_SOFT_REQ;
  assign wr_en    = acc.wr && acc.sel == dmac_reg_pkg::REG_CHN_EN;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // interrupt mask, status and clear
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge hclk or negedge hrst_n) begin
    if (!hrst_n) begin
      int_mask   <= '0;
      int_status <= '0;
      int_clear  <= '0;
    end else begin
      if (wr_mask) begin
        int_mask <= hwdata[dmac_reg_pkg::EVT_W-1:0];
      end
      // clear acts one cycle after its data phase
      int_clear  <= wr_clear ? hwdata[dmac_reg_pkg::EVT_W-1:0] : '0;
      // a new event beats a clear of the same bit
      int_status <= evt | (int_status & ~int_clear);
    end
  end

  assign irq  = int_en && |(int_status & int_mask);
  assign pend = int_status.pend;

  // software trigger comes out two cycles after the write data phase
  always_ff @(posedge hclk or negedge hrst_n) begin
    if (!hrst_n) begin
      soft_req <= 1'b0;
      sfwtrg   <= 1'b0;
    end else begin
      // back-to-back requests merge into one trigger
      soft_req <= wr_soft && hwdata[dmac_reg_pkg::SOFT_REQ_BIT] && !soft_req;
      sfwtrg   <= soft_req;
    end
  end

  always_ff @(posedge hclk or negedge hrst_n) begin
    if (!hrst_n) begin
      chn_en <= 1'b0;
    end else if (wr_en) begin
      chn_en <= hwdata[dmac_reg_pkg::CHN_EN_BIT];
    end else if (chnen_clr) begin
      chn_en <= 1'b0;
    end
  end

  // local registers override the read word of the config block
  always_comb begin
    hrdata = cfg_rdata;
    if (acc.rd) begin
      case (acc.sel)
        dmac_reg_pkg::REG_INT_MASK: begin
          hrdata = '0;
          hrdata[dmac_reg_pkg::EVT_W-1:0] = int_mask;
        end
        dmac_reg_pkg::REG_INT_STATUS: begin
          hrdata = '0;
          hrdata[dmac_reg_pkg::EVT_W-1:0] = int_status;
        end
        dmac_reg_pkg::REG_CHN_EN: begin
          hrdata = '0;
          hrdata[dmac_reg_pkg::CHN_EN_BIT] = chn_en;
        end
        default: ;
      endcase
    end
  end

  a_sfwtrg_single: assert property (@(posedge hclk) disable iff (!hrst_n)
    sfwtrg |=> !sfwtrg)
    else $error("sfwtrg held for more than one cycle");

endmodule

`default_nettype wire

/* verilog/dmac_chn_regs.sv */
/*
 * DMA channel register block, an AHB slave without wait states.
 */
`default_nettype none

module dmac_chn_regs (
  input  wire                               hclk,
  input  wire                               hrst_n,
  input  wire dmac_ahb_pkg::ahb_req_t       ahb_req,
  input  wire [dmac_ahb_pkg::DATA_W-1:0]    hwdata,
  output wire [dmac_ahb_pkg::DATA_W-1:0]    hrdata,
  input  wire dmac_reg_pkg::chn_evt_t       evt,
  input  wire                               chnen_clr,
  output wire dmac_reg_pkg::xfer_cfg_t      cfg,
  output wire                               chn_en,
  output wire                               irq,
  output wire                               pend,
  output wire                               sfwtrg
);

  dmac_reg_pkg::reg_acc_t            acc;
  logic                              int_en;
  logic [dmac_ahb_pkg::DATA_W-1:0]   cfg_rdata;

  dmac_ahb_decode u_decode (
    .hclk    (hclk),
    .hrst_n  (hrst_n),
    .ahb_req (ahb_req),
    .chn_en  (chn_en),
    .acc     (acc)
  );

  dmac_cfg_regs u_cfg (
    .hclk      (hclk),
    .hrst_n    (hrst_n),
    .acc       (acc),
    .hwdata    (hwdata),
    .cfg       (cfg),
    .int_en    (int_en),
    .cfg_rdata (cfg_rdata)
  );

  dmac_chn_ctl u_ctl (
    .hclk      (hclk),
    .hrst_n    (hrst_n),
    .acc       (acc),
    .hwdata    (hwdata),
    .evt       (evt),
    .chnen_clr (chnen_clr),
    .int_en    (int_en),
    .cfg_rdata (cfg_rdata),
    .chn_en    (chn_en),
    .irq       (irq),
    .pend      (pend),
    .sfwtrg    (sfwtrg),
    .hrdata    (hrdata)
  );

endmodule

`default_nettype wire

/* sim/tb_dmac_chn_regs.sv */
/*
 * Testbench for the DMA channel register block.
 * Directed AHB accesses, event pulses and checks of the channel outputs.
 */
`default_nettype none

module tb_dmac_chn_regs;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT_CYCLES = 2000;

  localparam logic [31:0] A_INT_MASK   = 32'h1c0;
  localparam logic [31:0] A_INT_STATUS = 32'h1c4;
  localparam logic [31:0] A_INT_CLEAR  = 32'h1c8;
  localparam logic [31:0] A_SOFT_REQ   = 32'h1cc;
  localparam logic [31:0] A_CHN_EN     = 32'h1d0;
  localparam logic [31:0] A_CTRL_B     = 32'h1bc;

  // SAR, DAR, CTRL_A, CTRL_B and GRPLEN_EXT with their implemented bits
  localparam logic [31:0] CFG_ADDR [5] = '{32'h1b0, 32'h1b4, 32'h1b8, 32'h1bc, 32'h1d4};
  localparam logic [31:0] CFG_MASK [5] = '{32'hffff_ffff, 32'hffff_ffff, 32'hb7ff_ffff,
                                           32'h0007_e007, 32'h0000_0003};

  logic                      hclk = 1'b0;
  logic                      hrst_n;
  dmac_ahb_pkg::ahb_req_t    ahb_req;
  logic [31:0]               hwdata;
  logic [31:0]               hrdata;
  dmac_reg_pkg::chn_evt_t    evt;
  logic                      chnen_clr;
  dmac_reg_pkg::xfer_cfg_t   cfg;
  logic                      chn_en;
  logic                      irq;
  logic                      pend;
  logic                      sfwtrg;

  int          errors = 0;
  int          cycles = 0;
  logic [31:0] rng = 32'hd610;
  logic [31:0] cfg_exp [5];

  dmac_chn_regs u_dmac_chn_regs (
    .hclk      (hclk),
    .hrst_n    (hrst_n),
    .ahb_req   (ahb_req),
    .hwdata    (hwdata),
    .hrdata    (hrdata),
    .evt       (evt),
    .chnen_clr (chnen_clr),
    .cfg       (cfg),
    .chn_en    (chn_en),
    .irq       (irq),
    .pend      (pend),
    .sfwtrg    (sfwtrg)
  );

  always #20 hclk = ~hclk;

  always @(posedge hclk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("errors: %0d", errors);
      $display("TB FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // bus and event drivers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // returns at the start of the data phase
  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
    @(posedge hclk);
    ahb_req.hsel   <= 1'b1;
    ahb_req.htrans <= dmac_ahb_pkg::NONSEQ;
    ahb_req.haddr  <= addr;
    ahb_req.hwrite <= 1'b1;
    @(posedge hclk);
    ahb_req.hsel   <= 1'b0;
    ahb_req.htrans <= dmac_ahb_pkg::IDLE;
    ahb_req.hwrite <= 1'b0;
    hwdata         <= data;
  endtask

  task automatic bus_read(input logic [31:0] addr, input logic [31:0] exp);
    @(posedge hclk);
    ahb_req.hsel   <= 1'b1;
    ahb_req.htrans <= dmac_ahb_pkg::NONSEQ;
    ahb_req.haddr  <= addr;
    ahb_req.hwrite <= 1'b0;
    @(posedge hclk);
    ahb_req.hsel   <= 1'b0;
    ahb_req.htrans <= dmac_ahb_pkg::IDLE;
    @(negedge hclk);
    check_word("hrdata", hrdata, exp);
  endtask

  task automatic pulse_evt(input dmac_reg_pkg::chn_evt_t bits);
    @(posedge hclk);
    evt <= bits;
    @(posedge hclk);
    evt <= '0;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // directed tests
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic test_reset_values();
    @(negedge hclk);
    check_word("irq", 32'(irq), 32'd0);
    check_word("pend", 32'(pend), 32'd0);
    check_word("sfwtrg", 32'(sfwtrg), 32'd0);
    check_word("chn_en", 32'(chn_en), 32'd0);
    for (int i = 0; i < 10; i++) begin
      bus_read(32'h1b0 + 32'(4 * i), 32'd0);
    end
  endtask

  task automatic test_cfg_rw();
    logic [31:0]             data [5];
    dmac_reg_pkg::xfer_cfg_t exp;
    for (int i = 0; i < 5; i++) begin
      rng = xorshift32(rng);
      data[i] = rng;
      cfg_exp[i] = rng & CFG_MASK[i];
      bus_write(CFG_ADDR[i], rng);
    end
    for (int i = 0; i < 5; i++) begin
      bus_read(CFG_ADDR[i], cfg_exp[i]);
    end
    exp.sar          = data[0];
    exp.dar          = data[1];
    exp.dgrpaddrc    = data[2][31];
    exp.sgrpaddrc    = data[2][29];
    exp.grpmc        = data[2][28];
    exp.chintmdc     = data[2][26:24];
    exp.block_tl     = data[2][23:12];
    exp.group_len    = {data[4][1:0], data[2][11:8]};
    exp.sinc         = data[2][7:6];
    exp.dinc         = data[2][5:4];
    exp.src_tr_width = data[2][3:2];
    exp.dst_tr_width = data[2][1:0];
    exp.protctl      = data[3][18:15];
    exp.endlan       = data[3][14];
    exp.srcdtlgc     = data[3][13];
    exp.trgtmdc      = data[3][2:1];
    assert (cfg === exp) else begin
      errors++;
      $display("** Error at %0t: cfg is %h, expected %h", $time, cfg, exp);
    end
  endtask

  task automatic test_enable_lock();
    bus_write(A_CHN_EN, 32'h1);
    bus_read(A_CHN_EN, 32'h1);
    for (int i = 0; i < 5; i++) begin
      rng = xorshift32(rng);
      bus_write(CFG_ADDR[i], rng);
    end
    for (int i = 0; i < 5; i++) begin
      bus_read(CFG_ADDR[i], cfg_exp[i]);
    end
    bus_write(A_INT_MASK, 32'h15);
    bus_read(A_INT_MASK, 32'h15);
    @(posedge hclk);
    chnen_clr <= 1'b1;
    @(posedge hclk);
    chnen_clr <= 1'b0;
    @(negedge hclk);
    check_word("chn_en", 32'(chn_en), 32'd0);
  endtask

  task automatic test_interrupts();
    bus_write(A_CTRL_B, 32'h1);
    bus_write(A_INT_MASK, 32'h1f);
    for (int b = 0; b < 5; b++) begin
      pulse_evt(5'(1 << b));
      @(negedge hclk);
      check_word("irq", 32'(irq), 32'd1);
      check_word("pend", 32'(pend), 32'(b == 4));
      bus_read(A_INT_STATUS, 32'(1 << b));
      bus_write(A_INT_MASK, 32'h1f & ~32'(1 << b));
      @(posedge hclk);
      @(negedge hclk);
      check_word("irq", 32'(irq), 32'd0);
      bus_write(A_INT_MASK, 32'h1f);
      bus_write(A_INT_CLEAR, 32'(1 << b));
      // status stays through N+2 and is gone in N+3
      for (int k = 1; k <= 3; k++) begin
        @(negedge hclk);
        check_word("irq", 32'(irq), 32'(k < 3));
      end
    end
    pulse_evt(5'h01);
    bus_write(A_CTRL_B, 32'h0);
    @(posedge hclk);
    @(negedge hclk);
    check_word("irq", 32'(irq), 32'd0);
    bus_write(A_CTRL_B, 32'h1);
    // event in the cycle where the clear pulse acts
    pulse_evt(5'h02);
    bus_write(A_INT_CLEAR, 32'h2);
    @(posedge hclk);
    evt <= 5'h02;
    @(posedge hclk);
    evt <= '0;
    bus_read(A_INT_STATUS, 32'h3);
    bus_write(A_INT_CLEAR, 32'h1f);
    bus_read(A_INT_STATUS, 32'h0);
  endtask

  task automatic test_soft_req();
    bus_write(A_SOFT_REQ, 32'h1);
    for (int k = 1; k <= 4; k++) begin
      @(negedge hclk);
      check_word("sfwtrg", 32'(sfwtrg), 32'(k == 3));
    end
    bus_write(A_SOFT_REQ, 32'h0);
    for (int k = 1; k <= 4; k++) begin
      @(negedge hclk);
      check_word("sfwtrg", 32'(sfwtrg), 32'd0);
    end
  endtask

  initial begin
    hrst_n    = 1'b0;
    ahb_req   = '0;
    hwdata    = '0;
    evt       = '0;
    chnen_clr = 1'b0;
    repeat (10) @(posedge hclk);
    hrst_n <= 1'b1;
    test_reset_values();
    test_cfg_rw();
    test_enable_lock();
    test_interrupts();
    test_soft_req();
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
verilog/dmac_ahb_pkg.sv
verilog/dmac_reg_pkg.sv
verilog/dmac_ahb_decode.sv
verilog/dmac_cfg_regs.sv
verilog/dmac_chn_ctl.sv
verilog/dmac_chn_regs.sv
sim/tb_dmac_chn_regs.sv

/* Makefile */
# Verilator build and run for the DMA channel register block

VERILATOR ?= verilator
TOP       ?= tb_dmac_chn_regs
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= TB PASSED
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# the run fails unless the log holds the pass message on a line of its own
run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
